// File: source/isaPkg.sv
package isaPkg;

	// major opcode in the top nibble of every instruction word
	typedef enum logic [3:0] {
		opAlu    = 4'd0,	// register form, func selects the operation
		opAddi   = 4'd1,	// rd = rd + imm8
		opMovi   = 4'd2,	// rd = imm8
		opLoad   = 4'd4,	// rd = mem[dataBase + rs[7:0]]
		opStore  = 4'd5,	// mem[dataBase + rs[7:0]] = rd
		opBranch = 4'd6,	// forward only, rd field is the condition
		opHalt   = 4'd15	// stop until reset
	} opcodeE;
	// 3, 7..14 unused, core treats them as nop

	// function field of register form, low nibble
	typedef enum logic [3:0] {
		fnAdd = 4'd0,
		fnSub = 4'd1,
		fnAnd = 4'd2,
		fnOr  = 4'd3,
		fnXor = 4'd4,
		fnShl = 4'd5,	// amount is rs[3:0]
		fnShr = 4'd6,	// logical, zero fill
		fnCmp = 4'd7	// flags only, rd left alone
	} aluFuncE;

	// branch condition, sits where rd normally is
	typedef enum logic [3:0] {
		condAlways = 4'd0,
		condEq     = 4'd1,	// zero set
		condNe     = 4'd2,	// zero clear
		condLo     = 4'd3,	// unsigned less than from cmp
		condLt     = 4'd4,	// signed less than from cmp
		condCs     = 4'd5	// carry set
	} condE;
	// anything above condCs never branches

	// opcode | rd | rs | func
	typedef struct packed {
		opcodeE    opcode;
		logic [3:0] rd;
		logic [3:0] rs;
		aluFuncE   func;
	} regFormT;

	// opcode | rd | imm8
	// also used by branch, imm8 is then the unsigned forward offset
	typedef struct packed {
		opcodeE    opcode;
		logic [3:0] rd;
		logic [7:0] imm;
	} immFormT;

	// one fetched word, read either way
	typedef union packed {
		regFormT r;
		immFormT i;
	} instrU;

endpackage

// File: source/corePkg.sv
package corePkg;

	// request toward the single port ram
	// read data comes back one cycle after addr
	typedef struct packed {
		logic [15:0] addr;
		logic        we;		// one cycle strobe, store only
		logic [15:0] wrData;
	} memReqT;

	// five flag leds, carry on the msb
	typedef struct packed {
		logic carry;	// add carry out, sub borrow
		logic low;		// unsigned a < b from cmp
		logic overflow;	// signed overflow of add/sub
		logic zero;		// a == b from cmp
		logic negative;	// signed a < b from cmp
	} flagsT;

	// sequencer states
	// three cycles per instruction, load/store add stMemory
	typedef enum logic [2:0] {
		stFetch   = 3'd0,	// pc on the address bus
		stDecode  = 3'd1,	// ram word arrives, latched into ir
		stExecute = 3'd2,	// write back, pc update
		stMemory  = 3'd3,	// data access for load/store
		stHalted  = 3'd4	// parked until reset
	} stateE;

endpackage

// File: source/registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input  logic        clk,
	input  logic        rstN,
	input  logic [3:0]  rdAddr,
	input  logic [3:0]  rsAddr,
	output logic [15:0] rdVal,
	output logic [15:0] rsVal,
	input  logic        we,
	input  logic [3:0]  wrAddr,
	input  logic [15:0] wrData,
	output logic [15:0] r1
);

	logic [15:0] regs [16];	// r0 is writable like the rest

	// single write port, lands on the clock edge
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= 16'h0000;
			end
		end else if (we) begin
			regs[wrAddr] <= wrData;
		end
	end

	// combinational reads, no bypass
	// a write shows up on the read port the cycle after
	assign rdVal = regs[rdAddr];
	assign rsVal = regs[rsAddr];

	assign r1 = regs[1];	// board display tap

endmodule

// File: source/alu.sv
`timescale 1ns/1ps

module alu (
	input  isaPkg::aluFuncE func,
	input  logic [15:0]     a,			// rd value
	input  logic [15:0]     b,			// rs value
	input  corePkg::flagsT  flagsIn,	// current flag register
	output logic [15:0]     result,
	output corePkg::flagsT  flagsOut
);

	logic [16:0] sum;		// bit 16 is carry out
	logic [16:0] diff;		// bit 16 is borrow
	logic        addOvf;
	logic        subOvf;
	logic [3:0]  shamt;

	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};

	// same sign in, other sign out
	assign addOvf = (a[15] == b[15]) && (sum[15] != a[15]);
	// signs differ and result took the sign of b
	assign subOvf = (a[15] != b[15]) && (diff[15] != a[15]);

	assign shamt = b[3:0];	// only the low nibble of rs counts

	always_comb begin
		result = a;			// cmp and unknown funcs pass rd through
		flagsOut = flagsIn;	// untouched unless the op says so

		case (func)
			isaPkg::fnAdd: begin
				result = sum[15:0];
				flagsOut.carry = sum[16];
				flagsOut.overflow = addOvf;
			end
			isaPkg::fnSub: begin
				result = diff[15:0];
				flagsOut.carry = diff[16];	// set on borrow
				flagsOut.overflow = subOvf;
			end
			isaPkg::fnAnd: result = a & b;
			isaPkg::fnOr:  result = a | b;
			isaPkg::fnXor: result = a ^ b;
			isaPkg::fnShl: result = a << shamt;
			isaPkg::fnShr: result = a >> shamt;	// logical
			isaPkg::fnCmp: begin
				// carry and overflow keep their old value
				flagsOut.zero = (a == b);
				flagsOut.low = (a < b);
				flagsOut.negative = ($signed(a) < $signed(b));
			end
			default: begin
				result = a;
				flagsOut = flagsIn;
			end
		endcase
	end

endmodule

// File: source/controlUnit.sv
`timescale 1ns/1ps

module controlUnit #(
	parameter logic [15:0] resetVector = 16'h0000,	// first fetch address
	parameter logic [15:0] dataBase = 16'hF000		// 256 word data page
) (
	input  logic            clk,
	input  logic            rstN,
	output corePkg::memReqT mem,
	input  logic [15:0]     readData,
	output logic            halted,
	output corePkg::flagsT  flags,
	output logic [3:0]      rdAddr,
	output logic [3:0]      rsAddr,
	input  logic [15:0]     rdVal,
	input  logic [15:0]     rsVal,
	output logic            regWe,
	output logic [3:0]      wrAddr,
	output logic [15:0]     wrData,
	output isaPkg::aluFuncE aluFunc,
	input  logic [15:0]     aluResult,
	input  corePkg::flagsT  aluFlags
);

	corePkg::stateE state;
	logic [15:0]    pc;
	isaPkg::instrU  ir;			// holds the word for execute and memory
	corePkg::flagsT flagReg;

	isaPkg::opcodeE opcode;
	isaPkg::condE   cond;
	logic           isMemOp;	// load or store
	logic           taken;
	logic [15:0]    immExt;		// imm8 zero extended
	logic [15:0]    dataAddr;
	logic [15:0]    pcNext;

	// field decode, both views of the same word
	assign opcode = ir.r.opcode;
	assign cond = isaPkg::condE'(ir.i.rd);	// branch reuses the rd nibble
	assign immExt = {8'h00, ir.i.imm};
	assign isMemOp = (opcode == isaPkg::opLoad) || (opcode == isaPkg::opStore);

	assign rdAddr = ir.r.rd;
	assign rsAddr = ir.r.rs;
	assign aluFunc = ir.r.func;

	assign dataAddr = dataBase + {8'h00, rsVal[7:0]};	// page offset from rs low byte

	// branch decision off the latched flags
	always_comb begin
		case (cond)
			isaPkg::condAlways: taken = 1'b1;
			isaPkg::condEq:     taken = flagReg.zero;
			isaPkg::condNe:     taken = !flagReg.zero;
			isaPkg::condLo:     taken = flagReg.low;
			isaPkg::condLt:     taken = flagReg.negative;
			isaPkg::condCs:     taken = flagReg.carry;
			default:            taken = 1'b0;
		endcase
	end

	// forward only, offset counts from the next word
	assign pcNext = pc + 16'd1 + ((opcode == isaPkg::opBranch && taken) ? immExt : 16'h0000);

	// write back source select
	always_comb begin
		case (opcode)
			isaPkg::opAddi: wrData = rdVal + immExt;
			isaPkg::opMovi: wrData = immExt;
			isaPkg::opLoad: wrData = readData;	// valid in stMemory
			default:        wrData = aluResult;
		endcase
	end

	assign wrAddr = ir.r.rd;

	// alu ops, addi, movi in execute; load one cycle later
	always_comb begin
		regWe = 1'b0;
		if (state == corePkg::stExecute) begin
			if (opcode == isaPkg::opAlu) begin
				regWe = (ir.r.func != isaPkg::fnCmp);	// cmp only touches flags
			end else if (opcode == isaPkg::opAddi || opcode == isaPkg::opMovi) begin
				regWe = 1'b1;
			end
		end else if (state == corePkg::stMemory) begin
			regWe = (opcode == isaPkg::opLoad);
		end
	end

	// data address goes out in execute so load data is back for memory
	assign mem.addr = (state != corePkg::stFetch && isMemOp) ? dataAddr : pc;
	assign mem.we = (state == corePkg::stMemory) && (opcode == isaPkg::opStore);
	assign mem.wrData = rdVal;	// store writes rd

	assign halted = (state == corePkg::stHalted);
	assign flags = flagReg;

	// sequencer, pc, ir and flag register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= corePkg::stFetch;
			pc <= resetVector;
			ir <= '0;
			flagReg <= '0;
		end else begin
			case (state)
				corePkg::stFetch: state <= corePkg::stDecode;
				corePkg::stDecode: begin
					ir <= readData;	// ram answered the fetch address
					state <= corePkg::stExecute;
				end
				corePkg::stExecute: begin
					pc <= pcNext;
					if (opcode == isaPkg::opAlu) begin
						flagReg <= aluFlags;	// alu already kept the unaffected bits
					end
					if (opcode == isaPkg::opHalt) begin
						state <= corePkg::stHalted;
					end else if (isMemOp) begin
						state <= corePkg::stMemory;
					end else begin
						state <= corePkg::stFetch;
					end
				end
				corePkg::stMemory: state <= corePkg::stFetch;
				default: state <= corePkg::stHalted;	// stays here until rstN
			endcase
		end
	end

endmodule

// File: source/cpuCore.sv
`timescale 1ns/1ps

module cpuCore #(
	parameter logic [15:0] resetVector = 16'h0000,
	parameter logic [15:0] dataBase = 16'hF000
) (
	input  logic            clk,
	input  logic            rstN,
	output corePkg::memReqT mem,
	input  logic [15:0]     readData,	// one cycle behind mem.addr
	output logic [15:0]     r1,
	output corePkg::flagsT  flags,
	output logic            halted
);

	// register file side
	logic [3:0]  rdAddr;
	logic [3:0]  rsAddr;
	logic [15:0] rdVal;
	logic [15:0] rsVal;
	logic        regWe;
	logic [3:0]  wrAddr;
	logic [15:0] wrData;

	// alu side
	isaPkg::aluFuncE aluFunc;
	logic [15:0]     aluResult;
	corePkg::flagsT  aluFlags;

	controlUnit #(
		.resetVector(resetVector),
		.dataBase(dataBase)
	) ctrl (
		.clk(clk),
		.rstN(rstN),
		.mem(mem),
		.readData(readData),
		.halted(halted),
		.flags(flags),
		.rdAddr(rdAddr),
		.rsAddr(rsAddr),
		.rdVal(rdVal),
		.rsVal(rsVal),
		.regWe(regWe),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.aluFunc(aluFunc),
		.aluResult(aluResult),
		.aluFlags(aluFlags)
	);

	registerFile regs (
		.clk(clk),
		.rstN(rstN),
		.rdAddr(rdAddr),
		.rsAddr(rsAddr),
		.rdVal(rdVal),
		.rsVal(rsVal),
		.we(regWe),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.r1(r1)
	);

	alu alu0 (
		.func(aluFunc),
		.a(rdVal),			// rd op rs
		.b(rsVal),
		.flagsIn(flags),	// unaffected bits fed back
		.result(aluResult),
		.flagsOut(aluFlags)
	);

endmodule

// File: test/cpuCore_chk.sv
`timescale 1ns/1ps

module cpuCoreChk (
	input logic           clk,
	input logic           rstN,
	input corePkg::stateE state,
	input logic           memWe,
	input logic           halted
);

	int failCount = 0;	// assertion failures so far

	// store strobe belongs to the memory cycle only
	weInMemory: assert property (@(posedge clk) disable iff (!rstN)
		memWe |-> state == corePkg::stMemory)
		else begin
			$error("write enable high in state %0d", state);
			failCount++;
		end

	// halted is sticky until reset
	haltHolds: assert property (@(posedge clk) disable iff (!rstN)
		halted |=> halted)
		else begin
			$error("halted dropped without a reset");
			failCount++;
		end

	// a fresh fetch comes only after execute or memory
	fetchOrigin: assert property (@(posedge clk) disable iff (!rstN)
		(state == corePkg::stFetch && $past(state) != corePkg::stFetch)
		|-> ($past(state) == corePkg::stExecute || $past(state) == corePkg::stMemory))
		else begin
			$error("fetch entered from neither execute nor memory");
			failCount++;
		end

endmodule

bind cpuCore cpuCoreChk chk (
	.clk(clk),
	.rstN(rstN),
	.state(ctrl.state),	// sequencer state inside the control unit
	.memWe(mem.we),
	.halted(halted)
);

// File: test/cpuMonitor.sv
`timescale 1ns/1ps

module cpuMonitor #(
	parameter logic [15:0] resetVector = 16'h0000,
	parameter logic [15:0] dataBase = 16'hF000
) (
	input  logic            clk,
	input  logic            start,	// image complete, run the model
	input  corePkg::memReqT mem,
	input  logic [15:0]     r1,
	input  corePkg::flagsT  flags,
	input  logic            halted,
	output int              storeErrors,
	output int              finalErrors,
	output logic            finalChecked
);

	logic [15:0] image [65536];		// memory as the model sees it
	logic [15:0] regs [16];
	corePkg::flagsT modelFlags;
	corePkg::memReqT storeQueue [$];	// expected strobes in program order
	int storesSeen;
	logic modelReady;

	task automatic setWord(input logic [15:0] addr, input logic [15:0] data);
		image[addr] = data;
	endtask

	function automatic int wordDiffers(input string what, input logic [15:0] expected,
			input logic [15:0] actual);
		if (expected === actual)
			return 0;
		$display("Mismatch %s: expected %h, actual %h", what, expected, actual);
		return 1;
	endfunction

	// add/sub result plus carry and overflow, judged on full-range integers
	function automatic void arith(input logic [3:0] rd, input int wide, input int signedWide);
		regs[rd] = wide[15:0];
		modelFlags.carry = (wide > 65535) || (wide < 0);	// carry out or borrow
		modelFlags.overflow = (signedWide > 32767) || (signedWide < -32768);
	endfunction

	// whole program in zero time, one instruction per pass
	task automatic runModel();
		isaPkg::instrU ir;
		logic [15:0] pc;
		logic [15:0] a;
		logic [15:0] b;
		corePkg::memReqT st;
		logic taken;
		pc = resetVector;
		modelFlags = '0;
		for (int i = 0; i < 16; i++) begin
			regs[i] = 16'h0000;
		end
		for (int steps = 0; steps < 4096; steps++) begin
			ir = image[pc];
			pc = pc + 16'd1;	// branch offset counts from here
			a = regs[ir.r.rd];
			b = regs[ir.r.rs];
			if (ir.r.opcode == isaPkg::opHalt)
				break;
			case (ir.r.opcode)
				isaPkg::opAlu: begin
					case (ir.r.func)
						isaPkg::fnAdd: arith(ir.r.rd, int'(a) + int'(b),
							int'($signed(a)) + int'($signed(b)));
						isaPkg::fnSub: arith(ir.r.rd, int'(a) - int'(b),
							int'($signed(a)) - int'($signed(b)));
						isaPkg::fnAnd: regs[ir.r.rd] = a & b;
						isaPkg::fnOr:  regs[ir.r.rd] = a | b;
						isaPkg::fnXor: regs[ir.r.rd] = a ^ b;
						isaPkg::fnShl: regs[ir.r.rd] = a << b[3:0];
						isaPkg::fnShr: regs[ir.r.rd] = a >> b[3:0];
						isaPkg::fnCmp: begin	// rd stays as it was
							modelFlags.zero = (a == b);
							modelFlags.low = (a < b);
							modelFlags.negative = ($signed(a) < $signed(b));
						end
						default: ;
					endcase
				end
				isaPkg::opAddi: regs[ir.i.rd] = a + {8'h00, ir.i.imm};
				isaPkg::opMovi: regs[ir.i.rd] = {8'h00, ir.i.imm};
				isaPkg::opLoad: regs[ir.r.rd] = image[dataBase + {8'h00, b[7:0]}];
				isaPkg::opStore: begin
					st.addr = dataBase + {8'h00, b[7:0]};
					st.we = 1'b1;
					st.wrData = a;
					image[st.addr] = a;	// later loads see it
					storeQueue.push_back(st);
				end
				isaPkg::opBranch: begin
					case (isaPkg::condE'(ir.i.rd))
						isaPkg::condAlways: taken = 1'b1;
						isaPkg::condEq:     taken = modelFlags.zero;
						isaPkg::condNe:     taken = !modelFlags.zero;
						isaPkg::condLo:     taken = modelFlags.low;
						isaPkg::condLt:     taken = modelFlags.negative;
						isaPkg::condCs:     taken = modelFlags.carry;
						default:            taken = 1'b0;
					endcase
					if (taken)
						pc = pc + {8'h00, ir.i.imm};
				end
				default: ;	// unused opcodes do nothing
			endcase
		end
	endtask

	initial begin
		storeErrors = 0;
		finalErrors = 0;
		finalChecked = 1'b0;
		modelReady = 1'b0;
		storesSeen = 0;
		wait (start);
		runModel();
		modelReady = 1'b1;
	end

	// core outputs are settled at the falling edge
	always @(negedge clk) begin
		corePkg::memReqT expected;
		if (modelReady && mem.we) begin
			if (halted || storeQueue.size() == 0) begin
				$display("Store to %h came after the last store of the program", mem.addr);
				storeErrors++;
			end else begin
				expected = storeQueue.pop_front();
				storeErrors += wordDiffers($sformatf("store %0d address", storesSeen),
					expected.addr, mem.addr);
				storeErrors += wordDiffers($sformatf("store %0d data", storesSeen),
					expected.wrData, mem.wrData);
				storesSeen++;
			end
		end
		if (modelReady && halted && !finalChecked) begin
			finalErrors += wordDiffers("final r1", regs[1], r1);
			finalErrors += wordDiffers("final flags", {11'h000, modelFlags}, {11'h000, flags});
			if (storeQueue.size() != 0) begin
				$display("Core halted with %0d stores still outstanding", storeQueue.size());
				finalErrors++;
			end
			finalChecked = 1'b1;
		end
	end

endmodule

// File: test/tbCpu.sv
`timescale 1ns/1ps

module tbCpu;

	localparam logic [15:0] resetVector = 16'h0040;	// off zero, exercises the parameter
	localparam logic [15:0] dataBase = 16'hF000;
	localparam int progLen = 120;
	localparam int tailCycles = 20;		// quiet window after halt
	localparam int watchCycles = 4 * progLen + 200;

	logic clk;
	logic rstN;
	logic [15:0] readData;
	corePkg::memReqT mem;
	logic [15:0] r1;
	corePkg::flagsT flags;
	logic halted;

	logic start;
	int storeErrors;
	int finalErrors;
	logic finalChecked;
	int otherErrors;
	int assertErrors;

	logic [15:0] ram [65536];
	logic [15:0] readLatch;
	logic [31:0] rngState;

	cpuCore #(.resetVector(resetVector), .dataBase(dataBase)) uut (
		.clk(clk),
		.rstN(rstN),
		.mem(mem),
		.readData(readData),
		.r1(r1),
		.flags(flags),
		.halted(halted)
	);

	cpuMonitor #(.resetVector(resetVector), .dataBase(dataBase)) mon (
		.clk(clk),
		.start(start),
		.mem(mem),
		.r1(r1),
		.flags(flags),
		.halted(halted),
		.storeErrors(storeErrors),
		.finalErrors(finalErrors),
		.finalChecked(finalChecked)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// single port ram, address taken on the rising edge
	always @(posedge clk) begin
		if (mem.we) begin
			ram[mem.addr] <= mem.wrData;
			readLatch <= mem.wrData;	// write cycle reads back the new word
		end else begin
			readLatch <= ram[mem.addr];
		end
	end
	always @(negedge clk) readData <= readLatch;	// lands mid next cycle

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [31:0] drawRandom();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	// same word into the ram and the model's image
	task automatic putWord(input logic [15:0] addr, input logic [15:0] data);
		ram[addr] = data;
		mon.setWord(addr, data);
	endtask

	task automatic buildProgram();
		isaPkg::instrU w;
		logic [31:0] r;
		int room;
		for (int k = 0; k < 256; k++) begin
			r = drawRandom();
			putWord(dataBase + 16'(k), r[15:0]);
		end
		for (int i = 0; i < progLen; i++) begin
			r = drawRandom();
			w.r.opcode = isaPkg::opAlu;
			w.r.rd = (r[5:4] == 2'b00) ? 4'd1 : r[11:8];	// lean toward r1
			w.r.rs = r[15:12];
			w.r.func = isaPkg::aluFuncE'({1'b0, r[18:16]});
			room = progLen - 2 - i;	// words left before the halt
			if (i < 16) begin
				w.i.opcode = isaPkg::opMovi;	// start value for every register
				w.i.rd = 4'(i);
				w.i.imm = r[27:20];
			end else if (i == progLen - 1) begin
				w.i.opcode = isaPkg::opHalt;
			end else begin
				case (r[3:0])
					4'd0, 4'd1, 4'd2, 4'd3, 4'd4: ;	// alu form already set
					4'd5, 4'd6: begin
						w.i.opcode = isaPkg::opAddi;
						w.i.imm = r[27:20];
					end
					4'd7, 4'd8: begin
						w.i.opcode = isaPkg::opMovi;
						w.i.imm = r[27:20];
					end
					4'd9, 4'd10, 4'd11, 4'd12: begin
						w.r.opcode = r[3:0] < 4'd11 ? isaPkg::opLoad : isaPkg::opStore;
						w.r.rs = {2'b11, r[13:12]};	// few address regs, so loads hit stores
					end
					default: begin
						w.i.opcode = isaPkg::opBranch;
						w.i.rd = {1'b0, r[22:20]};	// 6 and 7 never branch
						w.i.imm = 8'(int'(r[27:24]) % (room < 15 ? room + 1 : 16));
					end
				endcase
			end
			putWord(resetVector + 16'(i), w);
		end
	endtask

	// run limit from the program length
	initial begin
		wait (rstN);
		repeat (watchCycles) @(posedge clk);
		$display("Timeout: core did not halt within %0d cycles", watchCycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		rstN = 1'b0;
		readData = 16'h0000;
		start = 1'b0;
		otherErrors = 0;
		rngState = 32'h0cf81c2e;
		buildProgram();
		start = 1'b1;
		repeat (16) @(negedge clk);
		rstN = 1'b1;
		while (!halted) @(negedge clk);
		repeat (tailCycles) @(negedge clk);	// stray strobes after halt show up here
		if (!finalChecked) begin
			$display("Final r1 and flags were never compared");
			otherErrors++;
		end
		assertErrors = uut.chk.failCount;
		$display("errors: stores %0d, final state %0d, assertions %0d, other %0d",
			storeErrors, finalErrors, assertErrors, otherErrors);
		if (storeErrors + finalErrors + assertErrors + otherErrors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: project.f
source/isaPkg.sv
source/corePkg.sv
source/registerFile.sv
source/alu.sv
source/controlUnit.sv
source/cpuCore.sv
test/cpuCore_chk.sv
test/cpuMonitor.sv
test/tbCpu.sv

// File: run.sh
#!/bin/sh
# build and run the cpu testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbCpu -f project.f -o simCpu

# raised error limit lets assertion failures reach the closing summary
./obj_dir/simCpu +verilator+error+limit+1000 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"
